// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bev
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/bev_defs.svh ====
`ifndef BEV_DEFS_SVH
`define BEV_DEFS_SVH

// datapath widths
`define BEV_ING_W   12
`define BEV_DATA_W  64
`define BEV_ADDR_W  8

// cups per size
`define BEV_CUPS_L  4
`define BEV_CUPS_M  3
`define BEV_CUPS_S  2

// box record layout in the dram word
`define BEV_BT_MSB  63
`define BEV_BT_LSB  52
`define BEV_GT_MSB  51
`define BEV_GT_LSB  40
`define BEV_MON_MSB 35
`define BEV_MON_LSB 32
`define BEV_MLK_MSB 31
`define BEV_MLK_LSB 20
`define BEV_PJ_MSB  19
`define BEV_PJ_LSB  8
`define BEV_DAY_MSB 4
`define BEV_DAY_LSB 0

`endif

// ==== hw/bev_dram_pkg.sv ====
`default_nettype none

`include "bev_defs.svh"

package bev_dram_pkg;

    typedef logic [`BEV_ADDR_W-1:0] box_addr_t;
    typedef logic [`BEV_DATA_W-1:0] dram_word_t;

    typedef logic [`BEV_ING_W-1:0] bal_t;

    // unpacked view of one box, dates kept in record form
    typedef struct packed {
        bal_t                               bt;
        bal_t                               gt;
        bal_t                               mlk;
        bal_t                               pj;
        logic [`BEV_MON_MSB-`BEV_MON_LSB:0] mon;
        logic [`BEV_DAY_MSB-`BEV_DAY_LSB:0] day;
    } box_rec_t;

endpackage

`default_nettype wire

// ==== hw/bev_dram_port.sv ====
`default_nettype none

`include "bev_defs.svh"

module bev_dram_port import bev_dram_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    bev_mem_if.port    mem,
    output logic       c_in_valid,
    output logic       c_r_wb,
    output box_addr_t  c_addr,
    output dram_word_t c_data_w,
    input  logic       c_out_valid,
    input  dram_word_t c_data_r
);

    logic     pending;
    logic     pend_rd;
    box_rec_t rec_q;

    assign c_in_valid = mem.rd_req | mem.wr_req;
    assign c_r_wb     = mem.rd_req;
    assign c_addr     = mem.addr;

    // pack the record, unused bits stay zero
    always_comb begin
        c_data_w = '0;
        if (mem.wr_req) begin
            c_data_w[`BEV_BT_MSB:`BEV_BT_LSB]   = mem.wr_rec.bt;
            c_data_w[`BEV_GT_MSB:`BEV_GT_LSB]   = mem.wr_rec.gt;
            c_data_w[`BEV_MON_MSB:`BEV_MON_LSB] = mem.wr_rec.mon;
            c_data_w[`BEV_MLK_MSB:`BEV_MLK_LSB] = mem.wr_rec.mlk;
            c_data_w[`BEV_PJ_MSB:`BEV_PJ_LSB]   = mem.wr_rec.pj;
            c_data_w[`BEV_DAY_MSB:`BEV_DAY_LSB] = mem.wr_rec.day;
        end
    end

    // one request outstanding at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            pend_rd <= 1'b0;
        end else if (c_in_valid) begin
            pending <= 1'b1;
            pend_rd <= mem.rd_req;
        end else if (c_out_valid) begin
            pending <= 1'b0;
        end
    end

    assign mem.done = c_out_valid & pending;

    always_ff @(posedge clk) begin
        if (c_out_valid && pending && pend_rd) begin
            rec_q.bt  <= c_data_r[`BEV_BT_MSB:`BEV_BT_LSB];
            rec_q.gt  <= c_data_r[`BEV_GT_MSB:`BEV_GT_LSB];
            rec_q.mon <= c_data_r[`BEV_MON_MSB:`BEV_MON_LSB];
            rec_q.mlk <= c_data_r[`BEV_MLK_MSB:`BEV_MLK_LSB];
            rec_q.pj  <= c_data_r[`BEV_PJ_MSB:`BEV_PJ_LSB];
            rec_q.day <= c_data_r[`BEV_DAY_MSB:`BEV_DAY_LSB];
        end
    end

    assign mem.rd_rec = rec_q;

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        c_in_valid |-> !pending);

endmodule

`default_nettype wire

// ==== hw/bev_mem_if.sv ====
`default_nettype none

interface bev_mem_if import bev_dram_pkg::*; ();

    // request side
    logic      rd_req;
    logic      wr_req;
    box_addr_t addr;
    box_rec_t  wr_rec;

    // completion side
    logic      done;
    box_rec_t  rd_rec;

    modport seq (
        output rd_req, wr_req, addr, wr_rec,
        input  done, rd_rec
    );

    modport port (
        input  rd_req, wr_req, addr, wr_rec,
        output done, rd_rec
    );

endinterface

`default_nettype wire

// ==== hw/bev_order_pkg.sv ====
`default_nettype none

`include "bev_defs.svh"

package bev_order_pkg;

    typedef enum logic [1:0] {
        act_make_drink = 2'd0,
        act_supply     = 2'd1,
        act_check_date = 2'd2
    } action_t;

    // drink menu, same order as the recipe table
    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    typedef enum logic [1:0] {
        size_l = 2'd0,
        size_m = 2'd1,
        size_s = 2'd3
    } bev_size_t;

    typedef logic [`BEV_MON_MSB-`BEV_MON_LSB:0] month_t;
    typedef logic [`BEV_DAY_MSB-`BEV_DAY_LSB:0] day_t;

    typedef struct packed {
        month_t mon;
        day_t   day;
    } order_date_t;

    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2
    } err_msg_t;

    typedef logic [`BEV_ING_W-1:0] ing_t;

    // amount drawn from each ingredient for one drink
    typedef struct packed {
        ing_t bt;
        ing_t gt;
        ing_t mlk;
        ing_t pj;
    } ing_cost_t;

endpackage

`default_nettype wire

// ==== hw/bev_recipe_cost.sv ====
`default_nettype none

`include "bev_defs.svh"

module bev_recipe_cost import bev_order_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  bev_type_t bev_type,
    input  bev_size_t bev_size,
    output ing_cost_t cost
);

    ing_cost_t ratio;
    ing_cost_t cost_d;
    ing_t      cups;

    // per-cup ratios as bt, gt, mlk, pj
    always_comb begin
        case (bev_type)
            black_tea:                ratio = '{12'd240, 12'd0,   12'd0,   12'd0};
            milk_tea:                 ratio = '{12'd180, 12'd0,   12'd60,  12'd0};
            extra_milk_tea:           ratio = '{12'd120, 12'd0,   12'd120, 12'd0};
            green_tea:                ratio = '{12'd0,   12'd240, 12'd0,   12'd0};
            green_milk_tea:           ratio = '{12'd0,   12'd120, 12'd120, 12'd0};
            pineapple_juice:          ratio = '{12'd0,   12'd0,   12'd0,   12'd240};
            super_pineapple_tea:      ratio = '{12'd120, 12'd0,   12'd0,   12'd120};
            super_pineapple_milk_tea: ratio = '{12'd120, 12'd0,   12'd60,  12'd60};
            default:                  ratio = '0;
        endcase
    end

    always_comb begin
        case (bev_size)
            size_l:  cups = ing_t'(`BEV_CUPS_L);
            size_m:  cups = ing_t'(`BEV_CUPS_M);
            size_s:  cups = ing_t'(`BEV_CUPS_S);
            default: cups = '0;
        endcase
        cost_d.bt  = ratio.bt  * cups;
        cost_d.gt  = ratio.gt  * cups;
        cost_d.mlk = ratio.mlk * cups;
        cost_d.pj  = ratio.pj  * cups;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cost <= '0;
        end else begin
            cost <= cost_d;
        end
    end

    // the spare size code has no cup factor
    a_size_code: assert property (@(posedge clk) disable iff (!rst_n)
        bev_size != 2'd2);

endmodule

`default_nettype wire

// ==== hw/bev_sequencer.sv ====
`default_nettype none

module bev_sequencer import bev_order_pkg::*, bev_dram_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sel_action_valid,
    input  action_t     action,
    input  logic        type_valid,
    input  bev_type_t   bev_type,
    input  logic        size_valid,
    input  bev_size_t   bev_size,
    input  logic        date_valid,
    input  order_date_t date,
    input  logic        box_no_valid,
    input  box_addr_t   box_no,
    input  logic        expired,
    input  logic        short_stock,
    input  box_rec_t    upd_rec,
    bev_mem_if.seq      mem,
    output bev_type_t   type_r,
    output bev_size_t   size_r,
    output order_date_t date_r,
    output logic        is_make,
    output logic        out_valid,
    output err_msg_t    err_msg,
    output logic        complete
);

    typedef enum logic [3:0] {
        st_idle,
        st_get_type,
        st_get_size,
        st_get_date,
        st_get_box,
        st_rd_req,
        st_rd_wait,
        st_chk_exp,
        st_chk_ing,
        st_wr_req,
        st_wr_wait,
        st_done
    } state_t;

    state_t    state;
    state_t    nstate;
    box_addr_t box_r;
    err_msg_t  err_r;
    logic      accept;

    // supply (and the spare code) is dropped here
    assign accept = (state == st_idle) && sel_action_valid &&
                    (action == act_make_drink || action == act_check_date);

    // ========================================
    // state machine
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= nstate;
        end
    end

    always_comb begin
        nstate = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    nstate = (action == act_make_drink) ? st_get_type : st_get_date;
                end
            end
            st_get_type: if (type_valid)   nstate = st_get_size;
            st_get_size: if (size_valid)   nstate = st_get_date;
            st_get_date: if (date_valid)   nstate = st_get_box;
            st_get_box:  if (box_no_valid) nstate = st_rd_req;
            st_rd_req:   nstate = st_rd_wait;
            st_rd_wait:  if (mem.done)     nstate = st_chk_exp;
            // check date stops after the expiry test
            st_chk_exp:  nstate = (expired || !is_make) ? st_done : st_chk_ing;
            st_chk_ing:  nstate = short_stock ? st_done : st_wr_req;
            st_wr_req:   nstate = st_wr_wait;
            st_wr_wait:  if (mem.done)     nstate = st_done;
            st_done:     nstate = st_idle;
            default:     nstate = st_idle;
        endcase
    end

    // ========================================
    // order fields
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_make <= 1'b0;
            type_r  <= black_tea;
            size_r  <= size_l;
            date_r  <= '0;
            box_r   <= '0;
        end else begin
            if (accept) begin
                is_make <= (action == act_make_drink);
            end
            if (state == st_get_type && type_valid) begin
                type_r <= bev_type;
            end
            if (state == st_get_size && size_valid) begin
                size_r <= bev_size;
            end
            if (state == st_get_date && date_valid) begin
                date_r <= date;
            end
            if (state == st_get_box && box_no_valid) begin
                box_r <= box_no;
            end
        end
    end

    // error code follows the last check that ran
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_r <= no_err;
        end else if (accept) begin
            err_r <= no_err;
        end else if (state == st_chk_exp) begin
            err_r <= expired ? no_exp : no_err;
        end else if (state == st_chk_ing) begin
            err_r <= short_stock ? no_ing : no_err;
        end
    end

    // ========================================
    // dram requests and result
    // ========================================
    assign mem.rd_req = (state == st_rd_req);
    assign mem.wr_req = (state == st_wr_req);
    assign mem.addr   = box_r;
    assign mem.wr_rec = upd_rec;

    assign out_valid = (state == st_done);
    assign err_msg   = out_valid ? err_r : no_err;
    assign complete  = out_valid && (err_r == no_err);

    // completion only lands while a request is outstanding
    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mem.done |-> (state == st_rd_wait || state == st_wr_wait));

endmodule

`default_nettype wire

// ==== hw/bev_stock_check.sv ====
`default_nettype none

`include "bev_defs.svh"

module bev_stock_check import bev_order_pkg::*, bev_dram_pkg::*; (
    input  order_date_t date,
    input  box_rec_t    rd_rec,
    input  ing_cost_t   cost,
    output logic        expired,
    output logic        short_stock,
    output box_rec_t    upd_rec
);

    logic [`BEV_ING_W:0] left_bt;
    logic [`BEV_ING_W:0] left_gt;
    logic [`BEV_ING_W:0] left_mlk;
    logic [`BEV_ING_W:0] left_pj;

    // balance minus cost, top bit is the borrow
    function automatic logic [`BEV_ING_W:0] take(input bal_t bal, input ing_t amt);
        return {1'b0, bal} - {1'b0, amt};
    endfunction

    // record date earlier than today
    assign expired = (rd_rec.mon < date.mon) ||
                     (rd_rec.mon == date.mon && rd_rec.day < date.day);

    assign left_bt  = take(rd_rec.bt,  cost.bt);
    assign left_gt  = take(rd_rec.gt,  cost.gt);
    assign left_mlk = take(rd_rec.mlk, cost.mlk);
    assign left_pj  = take(rd_rec.pj,  cost.pj);

    assign short_stock = left_bt[`BEV_ING_W] | left_gt[`BEV_ING_W] |
                         left_mlk[`BEV_ING_W] | left_pj[`BEV_ING_W];

    assign upd_rec.bt  = left_bt[`BEV_ING_W-1:0];
    assign upd_rec.gt  = left_gt[`BEV_ING_W-1:0];
    assign upd_rec.mlk = left_mlk[`BEV_ING_W-1:0];
    assign upd_rec.pj  = left_pj[`BEV_ING_W-1:0];
    assign upd_rec.mon = rd_rec.mon;
    assign upd_rec.day = rd_rec.day;

endmodule

`default_nettype wire

// ==== hw/bev_top.sv ====
`default_nettype none

module bev_top import bev_order_pkg::*, bev_dram_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sel_action_valid,
    input  action_t     action,
    input  logic        type_valid,
    input  bev_type_t   bev_type,
    input  logic        size_valid,
    input  bev_size_t   bev_size,
    input  logic        date_valid,
    input  order_date_t date,
    input  logic        box_no_valid,
    input  box_addr_t   box_no,
    output logic        out_valid,
    output err_msg_t    err_msg,
    output logic        complete,
    output logic        c_in_valid,
    output logic        c_r_wb,
    output box_addr_t   c_addr,
    output dram_word_t  c_data_w,
    input  logic        c_out_valid,
    input  dram_word_t  c_data_r
);

    bev_type_t   type_r;
    bev_size_t   size_r;
    order_date_t date_r;
    ing_cost_t   cost;
    logic        expired;
    logic        short_stock;
    box_rec_t    upd_rec;

    bev_mem_if mem_bus ();

    bev_sequencer seq_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .type_valid       (type_valid),
        .bev_type         (bev_type),
        .size_valid       (size_valid),
        .bev_size         (bev_size),
        .date_valid       (date_valid),
        .date             (date),
        .box_no_valid     (box_no_valid),
        .box_no           (box_no),
        .expired          (expired),
        .short_stock      (short_stock),
        .upd_rec          (upd_rec),
        .mem              (mem_bus.seq),
        .type_r           (type_r),
        .size_r           (size_r),
        .date_r           (date_r),
        .is_make          (),
        .out_valid        (out_valid),
        .err_msg          (err_msg),
        .complete         (complete)
    );

    bev_recipe_cost cost_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bev_type (type_r),
        .bev_size (size_r),
        .cost     (cost)
    );

    bev_stock_check chk_i (
        .date        (date_r),
        .rd_rec      (mem_bus.rd_rec),
        .cost        (cost),
        .expired     (expired),
        .short_stock (short_stock),
        .upd_rec     (upd_rec)
    );

    bev_dram_port port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem         (mem_bus.port),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r)
    );

endmodule

`default_nettype wire

// ==== test/tb_bev.sv ====
`default_nettype none

`include "bev_defs.svh"

module tb_bev import bev_order_pkg::*, bev_dram_pkg::*; ();

    localparam int          clk_period = 100;
    localparam int          n_directed = 10;
    localparam int          n_random   = 40;
    localparam int          n_ops      = n_directed + n_random;
    localparam longint      run_limit  = longint'(n_ops * 40 + 20) * clk_period;
    localparam logic [31:0] lfsr_seed  = 32'h428f_d10d;

    typedef struct packed {
        err_msg_t   err;
        logic       cmpl;
        logic       wr;
        dram_word_t word;
    } result_t;

    logic        clk;
    logic        rst_n;
    logic        sel_action_valid;
    action_t     action;
    logic        type_valid;
    bev_type_t   bev_type;
    logic        size_valid;
    bev_size_t   bev_size;
    logic        date_valid;
    order_date_t date;
    logic        box_no_valid;
    box_addr_t   box_no;
    logic        out_valid;
    err_msg_t    err_msg;
    logic        complete;
    logic        c_in_valid;
    logic        c_r_wb;
    box_addr_t   c_addr;
    dram_word_t  c_data_w;
    logic        c_out_valid;
    dram_word_t  c_data_r;

    dram_word_t  mem_model [0:255];
    box_addr_t   cur_box = '0;
    dram_word_t  watch_word;
    logic [31:0] stim_st   = lfsr_seed;
    logic [31:0] bridge_st = lfsr_seed;

    assign watch_word = mem_model[cur_box];

    tb_clock #(.period(clk_period), .reset_cycles(2)) clk_i (.clk(clk), .rst_n(rst_n));

    bev_top dut_i (.*);

    tb_bev_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_valid   (out_valid),
        .err_msg     (err_msg),
        .complete    (complete),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .stored_word (watch_word)
    );

    // ========================================
    // random bits and helpers
    // ========================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    function automatic dram_word_t pack_word(input int bt, input int gt, input int mlk,
                                             input int pj, input int mon, input int day);
        dram_word_t w;
        w = '0;
        w[`BEV_BT_MSB:`BEV_BT_LSB]   = ing_t'(bt);
        w[`BEV_GT_MSB:`BEV_GT_LSB]   = ing_t'(gt);
        w[`BEV_MLK_MSB:`BEV_MLK_LSB] = ing_t'(mlk);
        w[`BEV_PJ_MSB:`BEV_PJ_LSB]   = ing_t'(pj);
        w[`BEV_MON_MSB:`BEV_MON_LSB] = month_t'(mon);
        w[`BEV_DAY_MSB:`BEV_DAY_LSB] = day_t'(day);
        return w;
    endfunction

    function automatic order_date_t on_day(input int m, input int d);
        order_date_t dt;
        dt.mon = month_t'(m);
        dt.day = day_t'(d);
        return dt;
    endfunction

    // expected outcome of one operation on the stored word
    function automatic result_t ref_result(input action_t op, input bev_type_t bt,
                                           input bev_size_t sz, input order_date_t dt,
                                           input dram_word_t w);
        result_t r;
        int      ratio [4];
        int      bal [4];
        int      left [4];
        int      cups;
        int      i;
        logic    short_f;
        month_t  mon;
        day_t    day;
        bal[0] = int'(w[`BEV_BT_MSB:`BEV_BT_LSB]);
        bal[1] = int'(w[`BEV_GT_MSB:`BEV_GT_LSB]);
        bal[2] = int'(w[`BEV_MLK_MSB:`BEV_MLK_LSB]);
        bal[3] = int'(w[`BEV_PJ_MSB:`BEV_PJ_LSB]);
        mon    = w[`BEV_MON_MSB:`BEV_MON_LSB];
        day    = w[`BEV_DAY_MSB:`BEV_DAY_LSB];
        // black tea, green tea, milk, pineapple juice per cup
        case (bt)
            black_tea:           ratio = '{240, 0, 0, 0};
            milk_tea:            ratio = '{180, 0, 60, 0};
            extra_milk_tea:      ratio = '{120, 0, 120, 0};
            green_tea:           ratio = '{0, 240, 0, 0};
            green_milk_tea:      ratio = '{0, 120, 120, 0};
            pineapple_juice:     ratio = '{0, 0, 0, 240};
            super_pineapple_tea: ratio = '{120, 0, 0, 120};
            default:             ratio = '{120, 0, 60, 60};
        endcase
        case (sz)
            size_l:  cups = `BEV_CUPS_L;
            size_m:  cups = `BEV_CUPS_M;
            default: cups = `BEV_CUPS_S;
        endcase
        r.err  = no_err;
        r.cmpl = 1'b0;
        r.wr   = 1'b0;
        r.word = w;
        if (mon < dt.mon || (mon == dt.mon && day < dt.day)) begin
            r.err = no_exp;
        end else if (op != act_make_drink) begin
            r.cmpl = 1'b1;
        end else begin
            short_f = 1'b0;
            for (i = 0; i < 4; i++) begin
                left[i] = bal[i] - ratio[i] * cups;
                if (left[i] < 0) begin
                    short_f = 1'b1;
                end
            end
            if (short_f) begin
                r.err = no_ing;
            end else begin
                r.cmpl = 1'b1;
                r.wr   = 1'b1;
                r.word = pack_word(left[0], left[1], left[2], left[3], int'(mon), int'(day));
            end
        end
        return r;
    endfunction

    // ========================================
    // dram bridge model
    // ========================================
    initial begin : bridge_model
        logic        req_rd;
        box_addr_t   req_addr;
        dram_word_t  req_data;
        logic [31:0] r;
        c_out_valid = 1'b0;
        c_data_r    = '0;
        forever begin
            @(negedge clk);
            c_out_valid = 1'b0;
            if (rst_n && c_in_valid) begin
                req_rd   = c_r_wb;
                req_addr = c_addr;
                req_data = c_data_w;
                take_bits(bridge_st, 3, r);
                // answer 1 to 8 cycles later
                repeat (int'(r[2:0]) + 1) @(negedge clk);
                if (req_rd) begin
                    c_data_r = mem_model[req_addr];
                end else begin
                    mem_model[req_addr] = req_data;
                end
                c_out_valid = 1'b1;
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================
    // sometimes an action strobe while the dut is capturing fields
    task automatic idle_gap();
        logic [31:0] r;
        take_bits(stim_st, 2, r);
        if (r[0]) begin
            sel_action_valid = r[1];
            action           = act_check_date;
            @(negedge clk);
            sel_action_valid = 1'b0;
        end
    endtask

    task automatic run_op(input action_t op, input bev_type_t bt, input bev_size_t sz,
                          input order_date_t dt, input box_addr_t box);
        result_t     e;
        logic [31:0] r;
        cur_box = box;
        e = ref_result(op, bt, sz, dt, mem_model[box]);
        chk_i.expect_result(e.err, e.cmpl, e.wr, e.word);
        // stray strobes while idle, supply code included
        take_bits(stim_st, 1, r);
        if (r[0]) begin
            sel_action_valid = 1'b1;
            action           = act_supply;
            type_valid       = 1'b1;
            bev_type         = bev_type_t'(~bt);
            box_no_valid     = 1'b1;
            box_no           = ~box;
            @(negedge clk);
            sel_action_valid = 1'b0;
            type_valid       = 1'b0;
            box_no_valid     = 1'b0;
        end
        sel_action_valid = 1'b1;
        action           = op;
        @(negedge clk);
        sel_action_valid = 1'b0;
        idle_gap();
        if (op == act_make_drink) begin
            type_valid = 1'b1;
            bev_type   = bt;
            @(negedge clk);
            type_valid = 1'b0;
            idle_gap();
            size_valid = 1'b1;
            bev_size   = sz;
            @(negedge clk);
            size_valid = 1'b0;
            idle_gap();
        end
        date_valid = 1'b1;
        date       = dt;
        @(negedge clk);
        date_valid = 1'b0;
        idle_gap();
        box_no_valid = 1'b1;
        box_no       = box;
        @(negedge clk);
        box_no_valid = 1'b0;
        do @(negedge clk); while (!out_valid);
        @(negedge clk);
    endtask

    initial begin : stimulus
        int          n;
        int          a;
        logic [31:0] r;
        action_t     op;
        bev_type_t   bt;
        bev_size_t   sz;
        order_date_t dt;
        box_addr_t   box;
        sel_action_valid = 1'b0;
        action           = act_make_drink;
        type_valid       = 1'b0;
        bev_type         = black_tea;
        size_valid       = 1'b0;
        bev_size         = size_l;
        date_valid       = 1'b0;
        date             = '0;
        box_no_valid     = 1'b0;
        box_no           = '0;
        for (a = 0; a < 256; a++) begin
            mem_model[a] = pack_word(a * 29 + 200, a * 53 + 700, a * 17 + 400,
                                     a * 41 + 900, 1 + a % 12, 1 + (a * 7) % 28);
            mem_model[a][39:36] = 4'(a >> 4);
        end
        @(posedge rst_n);
        // quiet stretch after reset
        repeat (10) @(negedge clk);

        // check valid date around the stored date
        mem_model[8'h10] = pack_word(1000, 1000, 1000, 1000, 6, 15);
        run_op(act_check_date, black_tea, size_l, on_day(6, 15), 8'h10);
        run_op(act_check_date, black_tea, size_l, on_day(6, 10), 8'h10);
        run_op(act_check_date, black_tea, size_l, on_day(6, 16), 8'h10);
        run_op(act_check_date, black_tea, size_l, on_day(7, 1), 8'h10);

        // make drink with enough stock
        mem_model[8'h11] = pack_word(2000, 2000, 2000, 2000, 12, 31);
        run_op(act_make_drink, black_tea, size_l, on_day(5, 20), 8'h11);
        run_op(act_make_drink, super_pineapple_milk_tea, size_m, on_day(5, 20), 8'h11);
        run_op(act_make_drink, green_milk_tea, size_s, on_day(12, 31), 8'h11);

        // expired box
        mem_model[8'h12] = pack_word(3000, 3000, 3000, 3000, 3, 1);
        run_op(act_make_drink, milk_tea, size_m, on_day(3, 2), 8'h12);

        // one balance short
        mem_model[8'h13] = pack_word(100, 4000, 4000, 4000, 12, 31);
        run_op(act_make_drink, milk_tea, size_s, on_day(1, 1), 8'h13);
        mem_model[8'h14] = pack_word(4000, 4000, 59, 4000, 12, 31);
        run_op(act_make_drink, super_pineapple_milk_tea, size_s, on_day(1, 1), 8'h14);

        // random mix on a few boxes so stock runs down
        for (n = 0; n < n_random; n++) begin
            take_bits(stim_st, 1, r);
            op = r[0] ? act_make_drink : act_check_date;
            take_bits(stim_st, 3, r);
            bt = bev_type_t'(r[2:0]);
            take_bits(stim_st, 2, r);
            sz = (r[1:0] == 2'd2) ? size_l : bev_size_t'(r[1:0]);
            take_bits(stim_st, 4, r);
            dt.mon = month_t'(1 + r[3:0] % 12);
            take_bits(stim_st, 5, r);
            dt.day = day_t'(1 + r[4:0] % 31);
            take_bits(stim_st, 4, r);
            box = 8'h20 + box_addr_t'(r[3:0]);
            run_op(op, bt, sz, dt, box);
        end

        repeat (5) @(negedge clk);
        if (chk_i.close_report() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(run_limit);
        $display("timeout: out_valid never came for an operation in flight");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_bev_checker.sv ====
`default_nettype none

module tb_bev_checker import bev_order_pkg::*, bev_dram_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       out_valid,
    input err_msg_t   err_msg,
    input logic       complete,
    input logic       c_in_valid,
    input logic       c_r_wb,
    input dram_word_t stored_word
);

    typedef struct packed {
        err_msg_t   err;
        logic       cmpl;
        logic       wr;
        dram_word_t word;
    } exp_t;

    exp_t exp_q[$];
    int   checks  = 0;
    int   errors  = 0;
    int   results = 0;
    int   writes  = 0;

    // one entry per operation, in issue order
    task automatic expect_result(input err_msg_t err, input logic cmpl, input logic wr,
                                 input dram_word_t word);
        exp_t e;
        e.err  = err;
        e.cmpl = cmpl;
        e.wr   = wr;
        e.word = word;
        exp_q.push_back(e);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ========================================
    // compare on the falling edge
    // ========================================
    always @(negedge clk) begin : watch
        exp_t e;
        if (rst_n && c_in_valid && !c_r_wb) begin
            writes++;
        end
        if (exp_q.size() == 0) begin
            // nothing in flight, outputs must stay quiet
            check_value("out_valid while idle", 64'(out_valid), 64'(0));
            check_value("complete while idle", 64'(complete), 64'(0));
            check_value("c_in_valid while idle", 64'(c_in_valid), 64'(0));
            check_value("err_msg while idle", 64'(err_msg), 64'(no_err));
        end else if (out_valid) begin
            e = exp_q.pop_front();
            check_value("err_msg", 64'(err_msg), 64'(e.err));
            check_value("complete", 64'(complete), 64'(e.cmpl));
            check_value("bridge writes", 64'(writes), 64'(e.wr));
            check_value("stored word", stored_word, e.word);
            writes = 0;
            results++;
        end else begin
            check_value("complete without out_valid", 64'(complete), 64'(0));
        end
    end

    // closing summary, returns the error total
    function automatic int close_report();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d operations ended without a result", exp_q.size());
        end
        $display("checks: %0d  results: %0d  errors: %0d", checks, results, errors);
        return errors;
    endfunction

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/bev_order_pkg.sv
hw/bev_dram_pkg.sv
hw/bev_mem_if.sv
hw/bev_sequencer.sv
hw/bev_recipe_cost.sv
hw/bev_stock_check.sv
hw/bev_dram_port.sv
hw/bev_top.sv
test/tb_clock.sv
test/tb_bev_checker.sv
test/tb_bev.sv
